//--- hw/adpll_pkg.sv
package adpll_pkg;

    localparam int ACCUM_W = 12;    // nco phase bits, sets the square wave
    localparam int PD_W    = 8;     // signed detector offset
    localparam int KP_W    = 5;     // proportional gain, unsigned
    localparam int KP_FRAC = 4;     // fractional bits of kp
    localparam int KI_W    = 8;     // integral gain, unsigned
    localparam int KI_FRAC = 7;     // fractional bits of ki
    localparam int INTEG_W = 20;    // signed integrator, saturating

    // detector output, err only meaningful while valid is high
    typedef struct packed {
        logic signed [PD_W-1:0] err;    // + when reference leads
        logic                   valid;  // one-cycle strobe
    } pd_result_t;

    // run-time loop gains, shared by both loops
    typedef struct packed {
        logic [KP_W-1:0] kp;    // q1.4
        logic [KI_W-1:0] ki;    // q1.7
    } loop_gains_t;

    typedef enum logic [1:0] {
        PD_IDLE,        // waiting for the first edge
        PD_REF_LEAD,    // reference edge seen, counting to generated edge
        PD_GEN_LEAD     // generated edge seen, counting to reference edge
    } pd_state_t;

endpackage

//--- hw/phase_accum.sv
`timescale 1ns/1ps

module phase_accum #(
    parameter int WIDTH = adpll_pkg::ACCUM_W
) (
    input  logic             fpga_clk_i,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] k_val_i,   // frequency word
    output logic             clk_o,     // square wave, period 2^WIDTH/k
    output logic             div8_o     // same wave divided by 8
);

    // three extra msbs give the divide-by-8 for free
    logic [WIDTH+2:0] accum_q;

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            accum_q <= '0;  // all clock outputs start low
        end else begin
            accum_q <= accum_q + {3'b000, k_val_i}; // wraps naturally
        end
    end

    assign clk_o  = accum_q[WIDTH-1];   // register bit, glitch free
    assign div8_o = accum_q[WIDTH+2];

    // a zero word would stall the oscillator and the loop behind it
    k_val_nonzero_a : assert property (
        @(posedge fpga_clk_i) disable iff (reset_i)
        k_val_i != '0
    ) else $error("phase_accum: frequency word is zero");

endmodule

//--- hw/phase_detector.sv
`timescale 1ns/1ps

module phase_detector #(
    parameter int WIDTH = adpll_pkg::PD_W
) (
    input  logic                  fpga_clk_i,
    input  logic                  reset_i,
    input  logic                  reference_i,  // clock-like, fabric register
    input  logic                  generated_i,  // clock-like, fabric register
    output adpll_pkg::pd_result_t result_o
);

    localparam logic [WIDTH-1:0] CNT_MAX = {1'b0, {(WIDTH-1){1'b1}}};   // 2^(W-1)-1

    logic [1:0]            ref_sync_q;  // two-flop synchroniser
    logic [1:0]            gen_sync_q;
    logic                  ref_prev_q;  // edge flop
    logic                  gen_prev_q;
    logic                  ref_edge;
    logic                  gen_edge;
    adpll_pkg::pd_state_t  state_q;
    logic [WIDTH-1:0]      count_q;     // cycles since leading edge
    logic [WIDTH-1:0]      count_inc;
    adpll_pkg::pd_result_t result_q;

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            ref_sync_q <= '0;
            gen_sync_q <= '0;
            ref_prev_q <= 1'b0;
            gen_prev_q <= 1'b0;
        end else begin
            ref_sync_q <= {ref_sync_q[0], reference_i};
            gen_sync_q <= {gen_sync_q[0], generated_i};
            ref_prev_q <= ref_sync_q[1];
            gen_prev_q <= gen_sync_q[1];
        end
    end

    assign ref_edge  = ref_sync_q[1] & ~ref_prev_q;    // rising only
    assign gen_edge  = gen_sync_q[1] & ~gen_prev_q;
    assign count_inc = (count_q == CNT_MAX) ? CNT_MAX : count_q + 1'b1;    // saturate

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            state_q  <= adpll_pkg::PD_IDLE;
            count_q  <= '0;
            result_q <= '0;
        end else begin
            result_q.valid <= 1'b0; // strobe by default
            case (state_q)
                adpll_pkg::PD_IDLE: begin
                    if (ref_edge && gen_edge) begin
                        result_q.err   <= '0;   // coincident, in phase
                        result_q.valid <= 1'b1;
                    end else if (ref_edge) begin
                        state_q <= adpll_pkg::PD_REF_LEAD;
                        count_q <= WIDTH'(1);
                    end else if (gen_edge) begin
                        state_q <= adpll_pkg::PD_GEN_LEAD;
                        count_q <= WIDTH'(1);
                    end
                end
                adpll_pkg::PD_REF_LEAD: begin
                    if (gen_edge) begin
                        result_q.err   <= signed'(count_q);    // gen lags, speed up
                        result_q.valid <= 1'b1;
                        state_q        <= adpll_pkg::PD_IDLE;
                    end else begin
                        count_q <= count_inc;
                    end
                end
                adpll_pkg::PD_GEN_LEAD: begin
                    if (ref_edge) begin
                        result_q.err   <= -signed'(count_q);   // gen leads, slow down
                        result_q.valid <= 1'b1;
                        state_q        <= adpll_pkg::PD_IDLE;
                    end else begin
                        count_q <= count_inc;
                    end
                end
                default: state_q <= adpll_pkg::PD_IDLE;
            endcase
        end
    end

    assign result_o = result_q;

    // filter consumes one strobe per measurement
    valid_single_a : assert property (
        @(posedge fpga_clk_i) disable iff (reset_i)
        result_q.valid |=> !result_q.valid
    ) else $error("phase_detector: valid held for two cycles");

endmodule

//--- hw/pi_loop_filter.sv
`timescale 1ns/1ps

module pi_loop_filter #(
    parameter int WIDTH = adpll_pkg::ACCUM_W,
    parameter int BIAS  = 154
) (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,    // level, low holds bias
    input  adpll_pkg::loop_gains_t gains_i,
    input  adpll_pkg::pd_result_t  err_i,
    output logic [WIDTH-1:0]       k_val_o      // frequency word for the nco
);

    localparam int IW    = adpll_pkg::INTEG_W;
    localparam int EW    = adpll_pkg::PD_W;
    localparam int SUM_W = IW + 2;  // room for bias + both terms

    localparam logic signed [IW:0]      INTEG_MAX = 2**(IW-1) - 1;
    localparam logic signed [IW:0]      INTEG_MIN = -(2**(IW-1));
    localparam logic signed [SUM_W-1:0] BIAS_S    = SUM_W'(BIAS);
    localparam logic signed [SUM_W-1:0] K_MAX     = 2**WIDTH - 1;

    logic signed [adpll_pkg::KP_W:0]    kp_s;       // gains made signed, always positive
    logic signed [adpll_pkg::KI_W:0]    ki_s;
    logic signed [adpll_pkg::KP_W+EW:0] kp_prod;
    logic signed [adpll_pkg::KI_W+EW:0] ki_prod;
    logic signed [IW:0]                 integ_sum;  // one guard bit
    logic signed [IW-1:0]               integ_next;
    logic signed [SUM_W-1:0]            word_sum;
    logic [WIDTH-1:0]                   word_clamped;
    logic signed [IW-1:0]               integ_q;
    logic [WIDTH-1:0]                   k_q;

    assign kp_s    = {1'b0, gains_i.kp};
    assign ki_s    = {1'b0, gains_i.ki};
    assign kp_prod = kp_s * err_i.err;
    assign ki_prod = ki_s * err_i.err;

    always_comb begin
        integ_sum = integ_q + ki_prod;
        if (integ_sum > INTEG_MAX) begin
            integ_next = IW'(INTEG_MAX);    // clip high
        end else if (integ_sum < INTEG_MIN) begin
            integ_next = IW'(INTEG_MIN);    // clip low
        end else begin
            integ_next = IW'(integ_sum);
        end
        // arithmetic shifts drop the fractional bits
        word_sum = BIAS_S + (kp_prod >>> adpll_pkg::KP_FRAC)
                 + (integ_next >>> adpll_pkg::KI_FRAC);
        if (word_sum < 1) begin
            word_clamped = WIDTH'(1);   // never stop the nco
        end else if (word_sum > K_MAX) begin
            word_clamped = WIDTH'(K_MAX);
        end else begin
            word_clamped = WIDTH'(word_sum);
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            integ_q <= '0;
            k_q     <= WIDTH'(BIAS);
        end else if (!enable_i) begin
            integ_q <= '0;              // open loop, free-run at bias
            k_q     <= WIDTH'(BIAS);
        end else if (err_i.valid) begin
            integ_q <= integ_next;      // update only on a measurement
            k_q     <= word_clamped;
        end
    end

    assign k_val_o = k_q;

    k_val_nonzero_a : assert property (
        @(posedge fpga_clk_i) disable iff (reset_i)
        k_q != '0
    ) else $error("pi_loop_filter: control word reached zero");

endmodule

//--- hw/adpll_core.sv
`timescale 1ns/1ps

module adpll_core #(
    parameter int WIDTH = adpll_pkg::ACCUM_W,
    parameter int BIAS  = 154
) (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,
    input  adpll_pkg::loop_gains_t gains_i,
    input  adpll_pkg::pd_result_t  err_i,       // from the detector outside
    output logic                   gen_clk_o,
    output logic                   gen_div8_o,  // fed back to the detector
    output logic [WIDTH-1:0]       k_val_o      // exposed to watch lock
);

    logic [WIDTH-1:0] k_val;

    pi_loop_filter #(
        .WIDTH (WIDTH),
        .BIAS  (BIAS)
    ) u_filter (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .gains_i    (gains_i),
        .err_i      (err_i),
        .k_val_o    (k_val)
    );

    // controlled oscillator, word straight from the filter
    phase_accum #(
        .WIDTH (WIDTH)
    ) u_nco (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .k_val_i    (k_val),
        .clk_o      (gen_clk_o),
        .div8_o     (gen_div8_o)
    );

    assign k_val_o = k_val;

endmodule

//--- hw/coupled_adpll_top.sv
`timescale 1ns/1ps

module coupled_adpll_top #(
    parameter int ACCUM_WIDTH = adpll_pkg::ACCUM_W,
    parameter int PD_WIDTH    = adpll_pkg::PD_W,
    parameter int BIAS        = 154     // nominal word of both loops
) (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,    // runs both loops
    input  adpll_pkg::loop_gains_t gains_i,
    input  logic [ACCUM_WIDTH-1:0] ref_k_i,     // reference frequency word
    output logic                   ref_clk_o,
    output logic                   gen_a_o,
    output logic                   div8_a_o,
    output logic                   gen_b_o,
    output logic                   div8_b_o,
    output adpll_pkg::pd_result_t  err_a_o,
    output adpll_pkg::pd_result_t  err_b_o,
    output logic [ACCUM_WIDTH-1:0] k_a_o,
    output logic [ACCUM_WIDTH-1:0] k_b_o
);

    // internal reference, its div8 is unused
    phase_accum #(.WIDTH(ACCUM_WIDTH)) u_ref_osc (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .k_val_i    (ref_k_i),
        .clk_o      (ref_clk_o),
        .div8_o     ()
    );

    phase_detector #(.WIDTH(PD_WIDTH)) pd_a (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .reference_i (ref_clk_o),
        .generated_i (div8_a_o),    // A runs at 8x the reference
        .result_o    (err_a_o)
    );

    adpll_core #(.WIDTH(ACCUM_WIDTH), .BIAS(BIAS)) core_a (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .gains_i    (gains_i),
        .err_i      (err_a_o),
        .gen_clk_o  (gen_a_o),
        .gen_div8_o (div8_a_o),
        .k_val_o    (k_a_o)
    );

    // second stage follows A, not the reference
    phase_detector #(.WIDTH(PD_WIDTH)) pd_b (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .reference_i (div8_a_o),
        .generated_i (div8_b_o),
        .result_o    (err_b_o)
    );

    adpll_core #(.WIDTH(ACCUM_WIDTH), .BIAS(BIAS-1)) core_b (    // off by one, must pull in
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .gains_i    (gains_i),
        .err_i      (err_b_o),
        .gen_clk_o  (gen_b_o),
        .gen_div8_o (div8_b_o),
        .k_val_o    (k_b_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;   // first rising edge at half a period
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released 1 ns after an edge, like the rest of the stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

//--- tb/tb_coupled_adpll.sv
`timescale 1ns/1ps

module tb_coupled_adpll;

    localparam int W          = adpll_pkg::ACCUM_W;
    localparam int BIAS       = 154;
    localparam int OPEN_CYC   = 4000;
    localparam int WINDOW_CYC = 3000;   // counted tail of the open-loop run
    localparam int FILTER_CYC = 3000;
    localparam int LOCK_CYC   = 60000;  // pull-in of both loops
    localparam int HOLD_CYC   = 4000;   // lock watched here
    localparam int RAND_CYC   = 4000;
    localparam int PAUSE_CYC  = 8;      // loops held open between settings
    localparam int RUN_CYC    = 4 + OPEN_CYC + 1 + 2 * PAUSE_CYC + FILTER_CYC + LOCK_CYC
                              + HOLD_CYC + 3 * (PAUSE_CYC + RAND_CYC);
    localparam int LIMIT_CYC  = RUN_CYC + RUN_CYC / 10;
    localparam int INTEG_MAX  = 2**(adpll_pkg::INTEG_W - 1) - 1;
    localparam int INTEG_MIN  = -(2**(adpll_pkg::INTEG_W - 1));
    localparam int K_MAX      = 2**W - 1;

    logic                   fpga_clk;
    logic                   reset;
    logic                   enable;
    adpll_pkg::loop_gains_t gains;
    logic [W-1:0]           ref_k;
    logic                   ref_clk;
    logic                   gen_a;
    logic                   div8_a;
    logic                   gen_b;
    logic                   div8_b;
    adpll_pkg::pd_result_t  err_a;
    adpll_pkg::pd_result_t  err_b;
    logic [W-1:0]           k_a;
    logic [W-1:0]           k_b;

    int          integ_a;       // model integrators
    int          integ_b;
    int          model_k_a;
    int          model_k_b;
    int          err_a_val;
    int          err_b_val;
    int          dev_a;
    int          dev_b;
    int          freq_edges;
    int          freq_err;
    logic        freq_chk;      // one-cycle request to check the edge count
    logic        lock_chk;      // high while lock is watched
    int          cur_test;
    int          fails [1:6] = '{default: 0};
    int          fail_total = 0;
    int          cycles = 0;
    logic [31:0] rng;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clk_gen (
        .clk_o   (fpga_clk),
        .reset_o (reset)
    );

    coupled_adpll_top #(.ACCUM_WIDTH(W), .PD_WIDTH(adpll_pkg::PD_W), .BIAS(BIAS)) UUT (
        .fpga_clk_i (fpga_clk),
        .reset_i    (reset),
        .enable_i   (enable),
        .gains_i    (gains),
        .ref_k_i    (ref_k),
        .ref_clk_o  (ref_clk),
        .gen_a_o    (gen_a),
        .div8_a_o   (div8_a),
        .gen_b_o    (gen_b),
        .div8_b_o   (div8_b),
        .err_a_o    (err_a),
        .err_b_o    (err_b),
        .k_a_o      (k_a),
        .k_b_o      (k_b)
    );

    assign err_a_val = int'($signed(err_a.err));
    assign err_b_val = int'($signed(err_b.err));
    assign dev_a     = int'(k_a) - 8 * int'(ref_k);    // A's div8 runs at the reference rate
    assign dev_b     = int'(k_b) - int'(k_a);          // B follows A's div8
    assign freq_err  = freq_edges * (2**W) - WINDOW_CYC * int'(ref_k);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // integrator after one strobe, saturating at its width
    function automatic int integ_next(int integ, int ki, int err);
        int sum;
        sum = integ + ki * err;
        if (sum > INTEG_MAX) sum = INTEG_MAX;
        if (sum < INTEG_MIN) sum = INTEG_MIN;
        return sum;
    endfunction

    function automatic int word_next(int bias, int kp, int err, int integ);
        int w;
        w = bias + ((kp * err) >>> adpll_pkg::KP_FRAC) + (integ >>> adpll_pkg::KI_FRAC);
        if (w < 1) w = 1;           // nco never stops
        if (w > K_MAX) w = K_MAX;
        return w;
    endfunction

    task automatic note_failure(int id);
        fails[id]++;
        fail_total++;
    endtask

    task automatic report_test(int id, string name);
        $display("test %0d (%s) finished with %0d failures", id, name, fails[id]);
    endtask

    task automatic run_cycles(int n);
        repeat (n) @(posedge fpga_clk);
        #1;                         // back to the drive point
    endtask

    // new gains and reference word, loops reopened then re-enabled
    task automatic restart_loops(int kp, int ki, int k);
        enable   = 1'b0;
        gains.kp = kp[adpll_pkg::KP_W-1:0];
        gains.ki = ki[adpll_pkg::KI_W-1:0];
        ref_k    = k[W-1:0];
        run_cycles(PAUSE_CYC);
        enable   = 1'b1;
    endtask

    // model of both filters, fed only by the observed strobes
    always @(posedge fpga_clk) begin
        int ia;
        int ib;
        ia = integ_next(integ_a, gains.ki, err_a_val);
        ib = integ_next(integ_b, gains.ki, err_b_val);
        if (reset || !enable) begin
            integ_a   <= 0;
            integ_b   <= 0;
            model_k_a <= BIAS;
            model_k_b <= BIAS - 1;  // B starts one count low
        end else begin
            if (err_a.valid) begin
                integ_a   <= ia;
                model_k_a <= word_next(BIAS, gains.kp, err_a_val, ia);
            end
            if (err_b.valid) begin
                integ_b   <= ib;
                model_k_b <= word_next(BIAS - 1, gains.kp, err_b_val, ib);
            end
        end
    end

    reset_state_a : assert property (@(posedge fpga_clk) reset |=> (!err_a.valid
        && !err_b.valid && !ref_clk && !gen_a && !div8_a && !gen_b && !div8_b
        && k_a == BIAS && k_b == BIAS - 1))
    else begin
        $display("Mismatch at %0t: outputs not at their reset values", $time);
        note_failure(1);
    end

    open_loop_a : assert property (@(posedge fpga_clk) disable iff (reset)
        !enable |=> (k_a == BIAS && k_b == BIAS - 1))
    else begin
        $display("Mismatch at %0t: words %0d/%0d not at bias while open", $time,
                 $sampled(k_a), $sampled(k_b));
        note_failure(cur_test);
    end

    freq_window_a : assert property (@(posedge fpga_clk) disable iff (reset)
        freq_chk |-> (freq_err <= 2**W && freq_err >= -(2**W)))
    else begin
        $display("Mismatch at %0t: %0d reference edges in %0d cycles", $time,
                 freq_edges, WINDOW_CYC);
        note_failure(2);
    end

    // model changes only on strobes, so this also covers hold between them
    word_model_a : assert property (@(posedge fpga_clk) disable iff (reset)
        enable |=> (k_a == model_k_a && k_b == model_k_b))
    else begin
        $display("Mismatch at %0t: k_a %0d model %0d, k_b %0d model %0d", $time,
                 $sampled(k_a), model_k_a, $sampled(k_b), model_k_b);
        note_failure(cur_test);
    end

    lock_a_a : assert property (@(posedge fpga_clk) disable iff (reset)
        lock_chk |-> (dev_a <= 2 && dev_a >= -2
        && (!err_a.valid || (err_a_val < 16 && err_a_val > -16))))
    else begin
        $display("Mismatch at %0t: loop A off lock, word offset %0d", $time, dev_a);
        note_failure(4);
    end

    lock_b_a : assert property (@(posedge fpga_clk) disable iff (reset)
        lock_chk |-> (dev_b <= 2 && dev_b >= -2
        && (!err_b.valid || (err_b_val < 16 && err_b_val > -16))))
    else begin
        $display("Mismatch at %0t: loop B off A, word offset %0d", $time, dev_b);
        note_failure(5);
    end

    word_nonzero_a : assert property (@(posedge fpga_clk) disable iff (reset)
        k_a != '0 && k_b != '0)
    else begin
        $display("Mismatch at %0t: a control word is zero", $time);
        note_failure(cur_test);
    end

    always @(posedge fpga_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic prev;
        int   kp;
        int   ki;
        enable     = 1'b0;
        gains      = '0;
        ref_k      = W'(BIAS);
        freq_chk   = 1'b0;
        freq_edges = 0;
        lock_chk   = 1'b0;
        cur_test   = 1;
        rng        = 32'h9cba_2802;
        @(negedge reset);
        run_cycles(1);
        report_test(1, "reset state");

        cur_test = 2;
        ref_k    = W'(BIAS + 20);           // away from bias to see the nco
        run_cycles(OPEN_CYC - WINDOW_CYC);
        prev = ref_clk;
        repeat (WINDOW_CYC) begin
            @(posedge fpga_clk);
            #1;
            if (ref_clk && !prev) freq_edges++;
            prev = ref_clk;
        end
        freq_chk = 1'b1;
        run_cycles(1);
        freq_chk = 1'b0;
        report_test(2, "open loop");

        cur_test = 3;
        restart_loops(12, 20, BIAS + 3);
        run_cycles(FILTER_CYC);
        report_test(3, "filter rule");

        cur_test = 4;
        restart_loops(16, 8, BIAS + 6);     // moderate damping
        run_cycles(LOCK_CYC);
        lock_chk = 1'b1;
        run_cycles(HOLD_CYC);
        lock_chk = 1'b0;
        report_test(4, "lock of A");
        report_test(5, "cascade lock of B");

        cur_test = 6;
        repeat (3) begin
            rng = xorshift32(rng);
            kp  = int'(rng % 32'd31) + 1;   // nonzero gains
            rng = xorshift32(rng);
            ki  = int'(rng % 32'd255) + 1;
            rng = xorshift32(rng);
            restart_loops(kp, ki, BIAS - 8 + int'(rng % 32'd17));
            run_cycles(RAND_CYC);
        end
        report_test(6, "random gains");

        $display("6 tests run, %0d failed checks", fail_total);
        if (fail_total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/adpll_pkg.sv
hw/phase_accum.sv
hw/phase_detector.sv
hw/pi_loop_filter.sv
hw/adpll_core.sv
hw/coupled_adpll_top.sv
tb/tb_clock_gen.sv
tb/tb_coupled_adpll.sv

//--- Bender.yml
package:
  name: coupled_adpll

sources:
  - hw/adpll_pkg.sv
  - hw/phase_accum.sv
  - hw/phase_detector.sv
  - hw/pi_loop_filter.sv
  - hw/adpll_core.sv
  - hw/coupled_adpll_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_coupled_adpll.sv
